// ==== files.f ====
hw/csr_pkg.sv
hw/csr_access_if.sv
hw/trap_if.sv
hw/csr_decoder.sv
hw/csr_bank.sv
hw/irq_arbiter.sv
hw/perf_counters.sv
hw/csr_unit_top.sv
tb/tb_csr_unit.sv

// ==== tb/csr_golden.txt ====
# name kind instr rs1_data pc code irq expected, all hex; exc takes instr as the trapping word
# kinds csr kill mret exc ack irq(expected pending level) cyc(expected lower bound)
wr_mstatus       csr  300110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mstatus       csr  300020F3 00000000 00000000 00 00000000 007E19AA
wr_misa          csr  301110F3 FFFFFFFF 00000000 00 00000000 40000100
rd_misa          csr  301020F3 00000000 00000000 00 00000000 7C000100
wr_mie           csr  304110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mie           csr  304020F3 00000000 00000000 00 00000000 00000888
wr_mtvec         csr  305110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mtvec         csr  305020F3 00000000 00000000 00 00000000 FFFFFFFC
wr_mscratch      csr  340110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mscratch      csr  340020F3 00000000 00000000 00 00000000 FFFFFFFF
wr_mepc          csr  341110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mepc          csr  341020F3 00000000 00000000 00 00000000 FFFFFFFC
wr_mcause        csr  342110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mcause        csr  342020F3 00000000 00000000 00 00000000 FFFFFFFF
wr_mtval         csr  343110F3 FFFFFFFF 00000000 00 00000000 00000000
rd_mtval         csr  343020F3 00000000 00000000 00 00000000 FFFFFFFF
rd_mvendorid     csr  F11020F3 00000000 00000000 00 00000000 00000000
rd_unmapped      csr  7C0020F3 00000000 00000000 00 00000000 00000000
wr_mscratch2     csr  340110F3 12345678 00000000 00 00000000 FFFFFFFF
set_mscratch     csr  340120F3 0000FF00 00000000 00 00000000 12345678
clr_mscratch     csr  340130F3 F0000000 00000000 00 00000000 1234FF78
clr_x0_mscratch  csr  340030F3 FFFFFFFF 00000000 00 00000000 0234FF78
clri_mie         csr  304470F3 00000000 00000000 00 00000000 00000888
seti_mie         csr  304FE0F3 00000000 00000000 00 00000000 00000880
rd_mie2          csr  304020F3 00000000 00000000 00 00000000 00000888
exc_illegal      exc  DEADBEEF 00000000 00001000 02 00000000 00001004
rd_mepc_exc      csr  341020F3 00000000 00000000 00 00000000 00001004
rd_mtval_exc     csr  343020F3 00000000 00000000 00 00000000 DEADBEEF
rd_mcause_exc    csr  342020F3 00000000 00000000 00 00000000 00000002
rd_mstatus_exc   csr  300020F3 00000000 00000000 00 00000000 007E19A2
mret_exc         mret 30200073 00000000 00000000 00 00000000 00000000
rd_mstatus_mret  csr  300020F3 00000000 00000000 00 00000000 007E19AA
exc_ecall        exc  00000073 00000000 00002000 0B 00000000 00002000
rd_mtval_ecall   csr  343020F3 00000000 00000000 00 00000000 00002000
mret_ecall       mret 30200073 00000000 00000000 00 00000000 00000000
irq_sw_tim       irq  00000000 00000000 00000000 00 00000088 00000001
ack_sw           ack  00000000 00000000 00003000 00 00000088 00003000
rd_mcause_sw     csr  342020F3 00000000 00000000 00 00000088 80000003
irq_masked       irq  00000000 00000000 00000000 00 00000888 00000000
mret_irq         mret 30200073 00000000 00000000 00 00000888 00000000
irq_ext          irq  00000000 00000000 00000000 00 00000888 00000001
ack_ext          ack  00000000 00000000 00004000 00 00000888 00004000
rd_mcause_ext    csr  342020F3 00000000 00000000 00 00000000 8000000B
kill_mscratch    kill 340110F3 AAAAAAAA 00000000 00 00000000 00000000
rd_mscratch_kill csr  340020F3 00000000 00000000 00 00000000 0234FF78
rd_instret       csr  C02020F3 00000000 00000000 00 00000000 00000025
rd_cycleh        csr  C80020F3 00000000 00000000 00 00000000 00000000
rd_cycle1        cyc  C00020F3 00000000 00000000 00 00000000 00000040
rd_cycle2        cyc  C00020F3 00000000 00000000 00 00000000 00000040

// ==== tb/tb_csr_unit.sv ====
`timescale 1ns/1ns

module tb_csr_unit;

    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_TEST = 40;
    localparam int PENDING_WINDOW  = 8;  // Cycles watched after the irq lines change

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_req_i, killed_i;
    logic [31:0] instruction_i, rs1_data_i;
    logic        instr_ack_o;
    logic [31:0] rd_data_o;
    logic        raise_exception_i;
    logic [4:0]  exception_code_i;
    logic [1:0]  privilege_i;
    logic [31:0] pc_i, trap_instruction_i;
    logic        interrupt_ack_i;
    logic [31:0] irq_i;
    logic        interrupt_pending_o;
    logic [31:0] mtvec_o, mepc_o;

    // One entry per golden line
    string       names[$];
    string       kinds[$];
    logic [31:0] instrs[$], rs1s[$], pcs[$], codes[$], irqs[$], expects[$];

    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          errors = 0;
    int          errors_before;
    int          passes = 0;
    int          fails = 0;
    logic [31:0] result;
    logic [31:0] last_cycle = '0;
    logic        seen_pending;

    csr_unit_top i_csr_unit_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic load_golden();
        int          fd;
        int          count;
        string       line, name, kind;
        logic [31:0] instr, rs1, pc, code, irq, exp;
        fd = $fopen("tb/csr_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file tb/csr_golden.txt");
            $display("Verification failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                count = $fgets(line, fd);
                if (line.len() < 2 || line.getc(0) == "#")
                    continue;  // Blank or column notes
                count = $sscanf(line, "%s %s %h %h %h %h %h %h",
                                name, kind, instr, rs1, pc, code, irq, exp);
                if (count != 8) begin
                    $display("Golden line could not be parsed: %s", line);
                    errors++;
                end else begin
                    names.push_back(name);
                    kinds.push_back(kind);
                    instrs.push_back(instr);
                    rs1s.push_back(rs1);
                    pcs.push_back(pc);
                    codes.push_back(code);
                    irqs.push_back(irq);
                    expects.push_back(exp);
                end
            end
            $fclose(fd);
        end
    endtask

    // Full four-phase exchange with the core side, called on a falling edge
    task automatic run_access(input logic [31:0] instr, input logic [31:0] rs1,
                              input logic kill, output logic [31:0] data);
        instruction_i = instr;
        rs1_data_i    = rs1;
        killed_i      = kill;
        instr_req_i   = 1'b1;
        do @(negedge clk); while (!instr_ack_o);
        data        = rd_data_o;
        instr_req_i = 1'b0;
        do @(negedge clk); while (instr_ack_o);
        killed_i = 1'b0;
    endtask

    task automatic pulse_exception(input logic [31:0] instr, input logic [31:0] pc,
                                   input logic [4:0] code);
        raise_exception_i  = 1'b1;
        exception_code_i   = code;
        pc_i               = pc;
        trap_instruction_i = instr;
        @(negedge clk);
        raise_exception_i = 1'b0;
    endtask

    task automatic pulse_int_ack(input logic [31:0] pc);
        interrupt_ack_i = 1'b1;
        pc_i            = pc;
        @(negedge clk);
        interrupt_ack_i = 1'b0;
    endtask

    task automatic watch_pending(output logic seen);
        seen = 1'b0;
        repeat (PENDING_WINDOW) begin
            @(negedge clk);
            seen = seen | interrupt_pending_o;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // CSRRS with x0 on mtvec, a read that leaves the register as it was
    function automatic logic is_mtvec_read(input logic [31:0] instr);
        return instr[31:20] == 12'h305 && instr[19:15] == 5'd0 && instr[14:12] == 3'b010;
    endfunction

    initial begin
        reset              = 1'b1;
        instr_req_i        = 1'b0;
        killed_i           = 1'b0;
        instruction_i      = '0;
        rs1_data_i         = '0;
        raise_exception_i  = 1'b0;
        exception_code_i   = '0;
        privilege_i        = 2'd3;  // Core always runs in M-mode
        pc_i               = '0;
        trap_instruction_i = '0;
        interrupt_ack_i    = 1'b0;
        irq_i              = '0;
        load_golden();
        cycle_limit = names.size() * CYCLES_PER_TEST + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (names[i]) begin
            errors_before = errors;
            @(negedge clk);
            irq_i = irqs[i];
            if (kinds[i] == "csr" || kinds[i] == "mret" || kinds[i] == "kill") begin
                run_access(instrs[i], rs1s[i], kinds[i] == "kill", result);
                check_value(names[i], expects[i], result);
                if (kinds[i] == "csr" && is_mtvec_read(instrs[i]))
                    check_value(names[i], expects[i], mtvec_o); // Port mirrors the register
            end else if (kinds[i] == "exc") begin
                pulse_exception(instrs[i], pcs[i], codes[i][4:0]);
                check_value(names[i], expects[i], mepc_o);
            end else if (kinds[i] == "ack") begin
                pulse_int_ack(pcs[i]);
                check_value(names[i], expects[i], mepc_o);
            end else if (kinds[i] == "irq") begin
                watch_pending(seen_pending);
                check_value(names[i], expects[i], {31'b0, seen_pending});
            end else if (kinds[i] == "cyc") begin
                run_access(instrs[i], rs1s[i], 1'b0, result);
                // Lower bound from the file, and strictly above the last CYCLE read
                assert (result >= expects[i] && result > last_cycle) else begin
                    $display("ERR %s expected at least %h and above %h actual %h",
                             names[i], expects[i], last_cycle, result);
                    errors++;
                end
                last_cycle = result;
            end else begin
                $display("Test %s has an unknown kind %s", names[i], kinds[i]);
                errors++;
            end
            if (errors == errors_before) begin
                passes++;
                $display("test %-18s ok", names[i]);
            end else begin
                fails++;
                $display("test %-18s failed", names[i]);
            end
        end

        $display("%0d tests passed, %0d tests failed", passes, fails);
        if (errors == 0 && passes > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== hw/csr_unit_top.sv ====
`timescale 1ns/1ns

module csr_unit_top
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_req_i,
    input  logic        killed_i,
    input  logic [31:0] instruction_i,
    input  logic [31:0] rs1_data_i,
    output logic        instr_ack_o,
    output logic [31:0] rd_data_o,
    input  logic        raise_exception_i,
    input  logic [4:0]  exception_code_i,
    input  logic [1:0]  privilege_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] trap_instruction_i,
    input  logic        interrupt_ack_i,
    input  logic [31:0] irq_i,
    output logic        interrupt_pending_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    logic        retire, mstatus_mie;
    logic [31:0] mip, mie;
    logic [63:0] cycle, instret;
    irq_code_e   int_code;

    csr_access_if csr_bus ();
    trap_if       trap_bus ();

    assign trap_bus.raise       = raise_exception_i;
    assign trap_bus.exc_code    = exc_code_e'(exception_code_i);
    assign trap_bus.privilege   = priv_e'(privilege_i);
    assign trap_bus.pc          = pc_i;
    assign trap_bus.instruction = trap_instruction_i;
    assign trap_bus.int_ack     = interrupt_ack_i;

    csr_decoder i_csr_decoder (
        .clk, .reset, .instr_req_i, .killed_i, .instruction_i(instr_u'(instruction_i)),
        .rs1_data_i, .instr_ack_o, .rd_data_o, .retire_o(retire), .csr(csr_bus)
    );

    csr_bank i_csr_bank (
        .clk, .reset, .csr(csr_bus), .trap(trap_bus), .int_code_i(int_code), .mip_i(mip),
        .cycle_i(cycle), .instret_i(instret), .mstatus_mie_o(mstatus_mie), .mie_o(mie),
        .mtvec_o, .mepc_o
    );

    irq_arbiter i_irq_arbiter (
        .clk, .reset, .irq_i, .mie_i(mie), .mstatus_mie_i(mstatus_mie),
        .int_ack_i(interrupt_ack_i), .mip_o(mip), .int_code_o(int_code), .interrupt_pending_o
    );

    perf_counters i_perf_counters (
        .clk, .reset, .retire_i(retire), .cycle_o(cycle), .instret_o(instret)
    );

endmodule

// ==== hw/perf_counters.sv ====
`timescale 1ns/1ns

module perf_counters (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire_i,
    output logic [63:0] cycle_o,
    output logic [63:0] instret_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_o   <= '0;
            instret_o <= '0;
        end else begin
            cycle_o <= cycle_o + 64'd1;
            if (retire_i)
                instret_o <= instret_o + 64'd1; // Killed accesses never pulse
        end
    end

endmodule

// ==== hw/irq_arbiter.sv ====
`timescale 1ns/1ns

module irq_arbiter
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic [31:0]        irq_i,
    input  logic [31:0]        mie_i,
    input  logic               mstatus_mie_i,
    input  logic               int_ack_i,
    output logic [31:0]        mip_o,
    output irq_code_e          int_code_o,
    output logic               interrupt_pending_o
);

    logic [31:0] enabled;

    assign enabled = mip_o & mie_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o               <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip_o               <= irq_i; // Sampled copy of the lines
            interrupt_pending_o <= mstatus_mie_i && (enabled != '0) && !int_ack_i;
        end
    end

    // Winner kept until the next pending cycle
    always_ff @(posedge clk) begin
        if (mstatus_mie_i && !int_ack_i) begin
            if (enabled[11])     int_code_o <= M_EXT_INT;
            else if (enabled[3]) int_code_o <= M_SW_INT;
            else if (enabled[7]) int_code_o <= M_TIM_INT;
        end
    end

endmodule

// ==== hw/csr_bank.sv ====
`timescale 1ns/1ns

module csr_bank
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    csr_access_if.slave        csr,
    trap_if.slave              trap,
    input  irq_code_e          int_code_i,
    input  logic [31:0]        mip_i,
    input  logic [63:0]        cycle_i,
    input  logic [63:0]        instret_i,
    output logic               mstatus_mie_o,
    output logic [31:0]        mie_o,
    output logic [31:0]        mtvec_o,
    output logic [31:0]        mepc_o
);

    csr_addr_e   addr;
    logic [31:0] mstatus, misa, mie, mtvec, mscratch, mepc, mcause, mtval;
    logic [31:0] cur_val, wmask, rd_val, new_val, wr_data;
    logic        access, do_mret, do_write;

    assign addr     = csr_addr_e'(csr.addr);
    assign access   = csr.req && !csr.ack; // First edge of a request
    assign do_mret  = access && csr.mret;
    assign do_write = access && !csr.mret && csr.op != CSR_NONE;

    // Stored value and write mask of the addressed register
    always_comb begin
        case (addr)
            MSTATUS:  begin cur_val = mstatus;  wmask = MASK_MSTATUS;  end
            MISA:     begin cur_val = misa;     wmask = MASK_MISA;     end
            MIE:      begin cur_val = mie;      wmask = MASK_MIE;      end
            MTVEC:    begin cur_val = mtvec;    wmask = MASK_MTVEC;    end
            MSCRATCH: begin cur_val = mscratch; wmask = MASK_MSCRATCH; end
            MEPC:     begin cur_val = mepc;     wmask = MASK_MEPC;     end
            MCAUSE:   begin cur_val = mcause;   wmask = MASK_MCAUSE;   end
            MTVAL:    begin cur_val = mtval;    wmask = MASK_MTVAL;    end
            default:  begin cur_val = '0;       wmask = '0;            end
        endcase
    end

    always_comb begin
        case (addr)
            MIP:      rd_val = mip_i;
            CYCLE:    rd_val = cycle_i[31:0];
            CYCLEH:   rd_val = cycle_i[63:32];
            INSTRET:  rd_val = instret_i[31:0];
            INSTRETH: rd_val = instret_i[63:32];
            MVENDORID, MARCHID, MIMPID, MHARTID, MCONFIGPTR:
                rd_val = '0; // ID registers not implemented
            default:  rd_val = cur_val;
        endcase
    end

    always_comb begin
        case (csr.op)
            CSR_WRITE: new_val = csr.wdata;
            CSR_SET:   new_val = cur_val | csr.wdata;
            CSR_CLEAR: new_val = cur_val & ~csr.wdata;
            default:   new_val = cur_val;
        endcase
        // Bits outside the mask keep their stored value
        wr_data = (cur_val & ~wmask) | (new_val & wmask);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            misa     <= MISA_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (do_mret) begin
            mstatus[MSTATUS_MIE] <= mstatus[MSTATUS_MPIE];
        end else if (trap.raise) begin
            mcause                         <= {1'b0, 26'b0, trap.exc_code};
            mstatus[MSTATUS_MPP_LO +: 2]   <= trap.privilege;
            mstatus[MSTATUS_MPIE]          <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]           <= 1'b0;
            // ECALL returns to itself, everything else to the next instruction
            mepc  <= (trap.exc_code == ECALL_FROM_MMODE) ? trap.pc : trap.pc + 32'd4;
            mtval <= (trap.exc_code == ILLEGAL_INSTRUCTION) ? trap.instruction : trap.pc;
        end else if (trap.int_ack) begin
            mcause                         <= {1'b1, 26'b0, int_code_i};
            mstatus[MSTATUS_MPP_LO +: 2]   <= trap.privilege;
            mstatus[MSTATUS_MPIE]          <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]           <= 1'b0;
            mepc                           <= trap.pc; // Interrupted instruction
        end else if (do_write) begin
            case (addr)
                MSTATUS:  mstatus  <= wr_data;
                MISA:     misa     <= wr_data;
                MIE:      mie      <= wr_data;
                MTVEC:    mtvec    <= wr_data;
                MSCRATCH: mscratch <= wr_data;
                MEPC:     mepc     <= wr_data;
                MCAUSE:   mcause   <= wr_data;
                MTVAL:    mtval    <= wr_data;
                default:  ; // Read-only or unmapped
            endcase
        end
    end

    // Bank side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (reset)
            csr.ack <= 1'b0;
        else if (access)
            csr.ack <= 1'b1;
        else if (!csr.req)
            csr.ack <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (access)
            csr.rdata <= rd_val; // Value before this write
    end

    assign mstatus_mie_o = mstatus[MSTATUS_MIE];
    assign mie_o         = mie;
    assign mtvec_o       = mtvec;
    assign mepc_o        = mepc;

endmodule

// ==== hw/csr_decoder.sv ====
`timescale 1ns/1ns

module csr_decoder
    import csr_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               instr_req_i,
    input  logic               killed_i,
    input  instr_u             instruction_i,
    input  logic [31:0]        rs1_data_i,
    output logic               instr_ack_o,
    output logic [31:0]        rd_data_o,
    output logic               retire_o,
    csr_access_if.master       csr
);

    typedef enum logic [1:0] {IDLE, ACCESS, DONE, RELEASE} state_e;

    state_e      state;
    csr_op_e     op_dec;
    logic [31:0] operand;
    logic        is_mret;

    always_comb begin
        is_mret = instruction_i.sys.opcode == OPC_SYSTEM &&
                  instruction_i.sys.funct3 == 3'b000 &&
                  instruction_i.sys.funct12 == FUNCT12_MRET;
        // funct3[2] selects the immediate forms
        operand = instruction_i.csr.funct3[2] ? {27'b0, instruction_i.csr.rs1} : rs1_data_i;
        case (instruction_i.csr.funct3[1:0])
            2'b01:   op_dec = CSR_WRITE;
            2'b10:   op_dec = CSR_SET;
            2'b11:   op_dec = CSR_CLEAR;
            default: op_dec = CSR_NONE;
        endcase
        if (op_dec != CSR_WRITE && instruction_i.csr.rs1 == 5'd0)
            op_dec = CSR_NONE; // Set/clear with x0 is just a read
        if (instruction_i.csr.opcode != OPC_SYSTEM)
            op_dec = CSR_NONE;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            csr.req     <= 1'b0;
            instr_ack_o <= 1'b0;
            retire_o    <= 1'b0;
        end else begin
            retire_o <= 1'b0;
            case (state)
                IDLE: if (instr_req_i && !csr.ack) state <= ACCESS; // Bank must be idle
                ACCESS: begin
                    if (killed_i) begin
                        instr_ack_o <= 1'b1; // Skip the bank entirely
                        state       <= RELEASE;
                    end else begin
                        csr.req <= 1'b1;
                        state   <= DONE;
                    end
                end
                DONE: begin
                    if (csr.ack) begin
                        csr.req     <= 1'b0;
                        instr_ack_o <= 1'b1;
                        retire_o    <= 1'b1;
                        state       <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!instr_req_i) begin
                        instr_ack_o <= 1'b0;
                        state       <= IDLE;
                    end
                end
            endcase
        end
    end

    // Access fields held stable for the whole bank handshake
    always_ff @(posedge clk) begin
        if (state == IDLE && instr_req_i) begin
            csr.op    <= op_dec;
            csr.addr  <= instruction_i.csr.addr;
            csr.wdata <= operand;
            csr.mret  <= is_mret;
        end
        if (state == ACCESS && killed_i)
            rd_data_o <= '0;
        else if (state == DONE && csr.ack)
            rd_data_o <= csr.rdata;
    end

endmodule

// ==== hw/trap_if.sv ====
`timescale 1ns/1ns

interface trap_if
    import csr_pkg::*;
();

    // Exception side
    logic        raise;
    exc_code_e   exc_code;
    priv_e       privilege;   // Privilege before the trap
    logic [31:0] pc;
    logic [31:0] instruction;

    // Interrupt side
    logic        int_ack;

    modport slave (
        input raise, exc_code, privilege, pc, instruction, int_ack
    );

endinterface

// ==== hw/csr_access_if.sv ====
`timescale 1ns/1ns

interface csr_access_if
    import csr_pkg::*;
();

    logic        req;
    logic        ack;
    csr_op_e     op;
    logic [11:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata; // Old value, valid with ack
    logic        mret;

    modport master (
        output req, op, addr, wdata, mret,
        input  ack, rdata
    );

    modport slave (
        input  req, op, addr, wdata, mret,
        output ack, rdata
    );

endinterface

// ==== hw/csr_pkg.sv ====
package csr_pkg;

    typedef enum logic [11:0] {
        MSTATUS    = 12'h300,
        MISA       = 12'h301,
        MIE        = 12'h304,
        MTVEC      = 12'h305,
        MSCRATCH   = 12'h340,
        MEPC       = 12'h341,
        MCAUSE     = 12'h342,
        MTVAL      = 12'h343,
        MIP        = 12'h344,
        CYCLE      = 12'hC00,
        INSTRET    = 12'hC02,
        CYCLEH     = 12'hC80,
        INSTRETH   = 12'hC82,
        MVENDORID  = 12'hF11,
        MARCHID    = 12'hF12,
        MIMPID     = 12'hF13,
        MHARTID    = 12'hF14,
        MCONFIGPTR = 12'hF15
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0, // Plain read
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [4:0] {
        INSTR_ADDR_MISALIGNED = 5'd0,
        INSTR_ACCESS_FAULT    = 5'd1,
        ILLEGAL_INSTRUCTION   = 5'd2,
        BREAKPOINT            = 5'd3,
        LOAD_ADDR_MISALIGNED  = 5'd4,
        LOAD_ACCESS_FAULT     = 5'd5,
        STORE_ADDR_MISALIGNED = 5'd6,
        STORE_ACCESS_FAULT    = 5'd7,
        ECALL_FROM_UMODE      = 5'd8,
        ECALL_FROM_SMODE      = 5'd9,
        ECALL_FROM_MMODE      = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        M_SW_INT  = 5'd3,
        M_TIM_INT = 5'd7,
        M_EXT_INT = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    // Writable bits of each CSR
    localparam logic [31:0] MASK_MSTATUS  = 32'h007E19AA;
    localparam logic [31:0] MASK_MISA     = 32'h3C000000;
    localparam logic [31:0] MASK_MIE      = 32'h00000888;
    localparam logic [31:0] MASK_MTVEC    = 32'hFFFFFFFC;
    localparam logic [31:0] MASK_MEPC     = 32'hFFFFFFFC;
    localparam logic [31:0] MASK_MSCRATCH = 32'hFFFFFFFF;
    localparam logic [31:0] MASK_MCAUSE   = 32'hFFFFFFFF;
    localparam logic [31:0] MASK_MTVAL    = 32'hFFFFFFFF;

    localparam logic [31:0] MISA_RESET = 32'h40000100; // RV32I

    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_MPP_LO = 11; // MPP is two bits wide

    localparam logic [6:0]  OPC_SYSTEM   = 7'b1110011;
    localparam logic [11:0] FUNCT12_MRET = 12'h302;

    // Same word seen as a CSR access or as a SYSTEM return
    typedef union packed {
        struct packed {
            logic [11:0] addr;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr;
        struct packed {
            logic [11:0] funct12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } sys;
    } instr_u;

endpackage
